/* rtl/fft_reg_pkg.sv */
//--------------------------------------------------------------------
// Post-processor register map
//--------------------------------------------------------------------

package fft_reg_pkg;

  // Byte address width of the register bus
  localparam int REG_ADDR_W = 4;

  // Register offsets
  localparam logic [REG_ADDR_W-1:0] REG_CTRL_ADDR = 4'h0;
  localparam logic [REG_ADDR_W-1:0] REG_MODE_ADDR = 4'h4;

  // Returned for any unmapped read
  localparam logic [31:0] REG_BAD_READ = 32'h0BAD_C0DE;

  // Output mode, value 3 is kept in the register and behaves as complex
  typedef enum logic [1:0] {
    MODE_COMPLEX = 2'd0,
    MODE_MAG     = 2'd1,
    MODE_MAG_SQ  = 2'd2
  } out_mode_t;

  localparam logic [1:0] AXIL_RESP_OKAY = 2'b00;

  // Values after reset
  localparam logic      CTRL_RESET = 1'b0;
  localparam out_mode_t MODE_RESET = MODE_COMPLEX;

endpackage

/* rtl/fft_dsp_pkg.sv */
//--------------------------------------------------------------------
// Post-processor sample formats
//--------------------------------------------------------------------

package fft_dsp_pkg;

  localparam int SAMPLE_W = 16;
  localparam int WORD_W   = 32;

  // Complex sample, real part in the upper half
  typedef struct packed {
    logic signed [SAMPLE_W-1:0] re;
    logic signed [SAMPLE_W-1:0] im;
  } iq_t;

  // One stream word, read either as a complex sample or as a power value
  typedef union packed {
    iq_t               iq;
    logic [WORD_W-1:0] power;
  } sample_word_t;

  //------------------------------------------------------------------
  // Rounding of power words down to 16 bits
  //------------------------------------------------------------------

  // Bits dropped by the rounding stage
  localparam int ROUND_SHIFT = 15;

  // Added before the shift for round half up
  localparam logic [WORD_W-1:0] ROUND_HALF = 32'd1 << (ROUND_SHIFT - 1);

  // Largest positive 16-bit result
  localparam logic [SAMPLE_W-1:0] OUT_MAX = 16'd32767;

endpackage

/* rtl/fft_regs.sv */
//--------------------------------------------------------------------
// AXI4-Lite control registers
//--------------------------------------------------------------------

module fft_regs
  import fft_reg_pkg::*;
#(
  parameter int EN_MAG_APPROX = 1,
  parameter int EN_MAG_SQ     = 1
) (
  input  logic                  ce_clk,
  input  logic                  i_rst,
  // Write address
  input  logic [REG_ADDR_W-1:0] i_awaddr,
  input  logic                  i_awvalid,
  output logic                  o_awready,
  // Write data
  input  logic [31:0]           i_wdata,
  input  logic                  i_wvalid,
  output logic                  o_wready,
  // Write response
  output logic [1:0]            o_bresp,
  output logic                  o_bvalid,
  input  logic                  i_bready,
  // Read address
  input  logic [REG_ADDR_W-1:0] i_araddr,
  input  logic                  i_arvalid,
  output logic                  o_arready,
  // Read data
  output logic [31:0]           o_rdata,
  output logic [1:0]            o_rresp,
  output logic                  o_rvalid,
  input  logic                  i_rready,
  // To the datapath
  output logic                  o_soft_rst,
  output out_mode_t             o_mode
);

  logic                  aw_held;
  logic                  w_held;
  logic [REG_ADDR_W-1:0] aw_addr_q;
  logic [31:0]           w_data_q;
  logic                  aw_hs;
  logic                  w_hs;
  logic                  ar_hs;
  logic                  wr_go;
  logic [REG_ADDR_W-1:0] wr_addr;
  logic [31:0]           wr_data;
  logic [31:0]           rd_mux;

  // Magnitude kinds that are not built fall back to complex
  function automatic out_mode_t legal_mode(input logic [1:0] val);
    out_mode_t m;
    m = out_mode_t'(val);
    if (m == MODE_MAG && EN_MAG_APPROX == 0) begin
      m = MODE_COMPLEX;
    end
    if (m == MODE_MAG_SQ && EN_MAG_SQ == 0) begin
      m = MODE_COMPLEX;
    end
    return m;
  endfunction

  //------------------------------------------------------------------
  // Write path
  //------------------------------------------------------------------

  // Address and data are taken on their own, one of each may wait
  assign o_awready = !aw_held;
  assign o_wready  = !w_held;
  assign aw_hs     = i_awvalid && o_awready;
  assign w_hs      = i_wvalid && o_wready;

  assign wr_addr = aw_held ? aw_addr_q : i_awaddr;
  assign wr_data = w_held ? w_data_q : i_wdata;

  // Commit once both halves are present and no response is pending
  assign wr_go = (aw_held || aw_hs) && (w_held || w_hs) && !o_bvalid;

  assign o_bresp = AXIL_RESP_OKAY;

  always_ff @(posedge ce_clk) begin
    if (aw_hs) begin
      aw_addr_q <= i_awaddr;
    end
    if (w_hs) begin
      w_data_q <= i_wdata;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      aw_held    <= 1'b0;
      w_held     <= 1'b0;
      o_bvalid   <= 1'b0;
      o_soft_rst <= CTRL_RESET;
      o_mode     <= MODE_RESET;
    end else begin
      if (wr_go) begin
        aw_held <= 1'b0;
      end else if (aw_hs) begin
        aw_held <= 1'b1;
      end
      if (wr_go) begin
        w_held <= 1'b0;
      end else if (w_hs) begin
        w_held <= 1'b1;
      end
      if (wr_go) begin
        o_bvalid <= 1'b1;
      end else if (i_bready) begin
        o_bvalid <= 1'b0;
      end
      if (wr_go && wr_addr == REG_CTRL_ADDR) begin
        o_soft_rst <= wr_data[0];
      end
      if (wr_go && wr_addr == REG_MODE_ADDR) begin
        o_mode <= legal_mode(wr_data[1:0]);
      end
    end
  end

  //------------------------------------------------------------------
  // Read path
  //------------------------------------------------------------------

  assign o_arready = !o_rvalid;
  assign ar_hs     = i_arvalid && o_arready;
  assign o_rresp   = AXIL_RESP_OKAY;

  always_comb begin
    case (i_araddr)
      REG_CTRL_ADDR: rd_mux = {31'd0, o_soft_rst};
      REG_MODE_ADDR: rd_mux = {30'd0, o_mode};
      default:       rd_mux = REG_BAD_READ;
    endcase
  end

  always_ff @(posedge ce_clk) begin
    if (ar_hs) begin
      o_rdata <= rd_mux;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      o_rvalid <= 1'b0;
    end else if (ar_hs) begin
      o_rvalid <= 1'b1;
    end else if (i_rready) begin
      o_rvalid <= 1'b0;
    end
  end

  // Response stays up until the master takes it
  a_bvalid_hold: assert property (@(posedge ce_clk) disable iff (i_rst)
    o_bvalid && !i_bready |=> o_bvalid);

endmodule

/* rtl/fft_frame_mode.sv */
//--------------------------------------------------------------------
// Frame-aligned output mode capture
//--------------------------------------------------------------------

module fft_frame_mode
  import fft_reg_pkg::*, fft_dsp_pkg::*;
(
  input  logic         ce_clk,
  input  logic         i_rst,
  input  logic         i_soft_rst,
  input  out_mode_t    i_mode,
  input  sample_word_t i_tdata,
  input  logic         i_tlast,
  input  logic         i_tvalid,
  output logic         o_tready,
  output sample_word_t o_tdata,
  output logic         o_tlast,
  output logic         o_tvalid,
  output out_mode_t    o_mode_tag,
  input  logic         i_tready
);

  logic      at_start;
  out_mode_t frame_mode;
  logic      in_hs;
  logic      out_hs;
  logic      out_open;
  out_mode_t out_tag;

  assign o_tready = !i_soft_rst && (!o_tvalid || i_tready);
  assign in_hs    = i_tvalid && o_tready;
  assign out_hs   = o_tvalid && i_tready;

  // Mode is sampled on the first beat of every frame
  always_ff @(posedge ce_clk) begin
    if (i_rst || i_soft_rst) begin
      at_start   <= 1'b1;
      frame_mode <= MODE_RESET;
      o_tvalid   <= 1'b0;
    end else begin
      if (in_hs) begin
        at_start <= i_tlast;
        if (at_start) begin
          frame_mode <= i_mode;
        end
      end
      if (in_hs) begin
        o_tvalid <= 1'b1;
      end else if (out_hs) begin
        o_tvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge ce_clk) begin
    if (in_hs) begin
      o_tdata    <= i_tdata;
      o_tlast    <= i_tlast;
      o_mode_tag <= at_start ? i_mode : frame_mode;
    end
  end

  // Output side history of the frame in progress
  always_ff @(posedge ce_clk) begin
    if (i_rst || i_soft_rst) begin
      out_open <= 1'b0;
    end else if (out_hs) begin
      out_open <= !o_tlast;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (out_hs) begin
      out_tag <= o_mode_tag;
    end
  end

  a_tag_steady: assert property (@(posedge ce_clk) disable iff (i_rst || i_soft_rst)
    o_tvalid && out_open |-> o_mode_tag == out_tag);

endmodule

/* rtl/fft_mag_unit.sv */
//--------------------------------------------------------------------
// Magnitude and power pipeline
//--------------------------------------------------------------------

module fft_mag_unit
  import fft_reg_pkg::*, fft_dsp_pkg::*;
#(
  parameter int EN_MAG_APPROX = 1,
  parameter int EN_MAG_SQ     = 1
) (
  input  logic         ce_clk,
  input  logic         i_rst,
  input  logic         i_soft_rst,
  input  sample_word_t i_tdata,
  input  logic         i_tlast,
  input  logic         i_tvalid,
  output logic         o_tready,
  input  out_mode_t    i_mode_tag,
  output sample_word_t o_tdata,
  output logic         o_tlast,
  output logic         o_tvalid,
  output logic         o_is_power,
  input  logic         i_tready
);

  logic                s1_valid;
  logic                s1_last;
  sample_word_t        s1_word;
  out_mode_t           s1_mode;
  logic [SAMPLE_W-1:0] s1_abs_re;
  logic [SAMPLE_W-1:0] s1_abs_im;
  logic [WORD_W-1:0]   s1_sq_re;
  logic [WORD_W-1:0]   s1_sq_im;
  logic                s1_ready;
  logic                s1_load;
  logic                s2_load;
  logic [SAMPLE_W-1:0] abs_re;
  logic [SAMPLE_W-1:0] abs_im;
  logic [SAMPLE_W-1:0] mag_max;
  logic [SAMPLE_W-1:0] mag_min;
  logic [SAMPLE_W:0]   mag_sum;
  logic [SAMPLE_W-1:0] mag_sat;
  logic [WORD_W-1:0]   sq_sum;
  sample_word_t        result;
  logic                result_power;

  assign s1_ready = !o_tvalid || i_tready;
  assign o_tready = !i_soft_rst && (!s1_valid || s1_ready);
  assign s1_load  = i_tvalid && o_tready;
  assign s2_load  = s1_valid && s1_ready;

  // -32768 maps to 0x8000, which is correct as unsigned
  assign abs_re = i_tdata.iq.re[SAMPLE_W-1] ? -i_tdata.iq.re : i_tdata.iq.re;
  assign abs_im = i_tdata.iq.im[SAMPLE_W-1] ? -i_tdata.iq.im : i_tdata.iq.im;

  always_ff @(posedge ce_clk) begin
    if (i_rst || i_soft_rst) begin
      s1_valid <= 1'b0;
      o_tvalid <= 1'b0;
    end else begin
      if (s1_load) begin
        s1_valid <= 1'b1;
      end else if (s2_load) begin
        s1_valid <= 1'b0;
      end
      if (s2_load) begin
        o_tvalid <= 1'b1;
      end else if (i_tready) begin
        o_tvalid <= 1'b0;
      end
    end
  end

  //------------------------------------------------------------------
  // Stage one, absolute values and squares
  //------------------------------------------------------------------

  always_ff @(posedge ce_clk) begin
    if (s1_load) begin
      s1_last   <= i_tlast;
      s1_word   <= i_tdata;
      s1_mode   <= i_mode_tag;
      s1_abs_re <= abs_re;
      s1_abs_im <= abs_im;
      s1_sq_re  <= WORD_W'(abs_re) * WORD_W'(abs_re);
      s1_sq_im  <= WORD_W'(abs_im) * WORD_W'(abs_im);
    end
  end

  //------------------------------------------------------------------
  // Stage two, result by mode
  //------------------------------------------------------------------

  always_comb begin
    mag_max = (s1_abs_re > s1_abs_im) ? s1_abs_re : s1_abs_im;
    mag_min = (s1_abs_re > s1_abs_im) ? s1_abs_im : s1_abs_re;
    // max + min/2 approximation
    mag_sum = {1'b0, mag_max} + {2'b00, mag_min[SAMPLE_W-1:1]};
    mag_sat = (mag_sum > {1'b0, OUT_MAX}) ? OUT_MAX : mag_sum[SAMPLE_W-1:0];
    sq_sum  = s1_sq_re + s1_sq_im;

    result       = s1_word;
    result_power = 1'b0;
    if (s1_mode == MODE_MAG && EN_MAG_APPROX != 0) begin
      // Scaled up so the rounding stage returns it unchanged
      result.power = WORD_W'(mag_sat) << ROUND_SHIFT;
      result_power = 1'b1;
    end else if (s1_mode == MODE_MAG_SQ && EN_MAG_SQ != 0) begin
      result.power = sq_sum;
      result_power = 1'b1;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (s2_load) begin
      o_tdata    <= result;
      o_tlast    <= s1_last;
      o_is_power <= result_power;
    end
  end

endmodule

/* rtl/fft_round_clip.sv */
//--------------------------------------------------------------------
// Round and clip of power words
//--------------------------------------------------------------------

module fft_round_clip
  import fft_dsp_pkg::*;
(
  input  logic         ce_clk,
  input  logic         i_rst,
  input  logic         i_soft_rst,
  input  sample_word_t i_tdata,
  input  logic         i_tlast,
  input  logic         i_tvalid,
  output logic         o_tready,
  input  logic         i_is_power,
  output sample_word_t o_tdata,
  output logic         o_tlast,
  output logic         o_tvalid,
  input  logic         i_tready
);

  logic [WORD_W:0]             rnd_sum;
  logic [WORD_W-ROUND_SHIFT:0] rnd_val;
  logic [SAMPLE_W-1:0]         clip_val;
  sample_word_t                rc_word;
  logic                        in_hs;

  assign o_tready = !i_soft_rst && (!o_tvalid || i_tready);
  assign in_hs    = i_tvalid && o_tready;

  // One extra bit keeps the carry of the rounding add
  always_comb begin
    rnd_sum  = {1'b0, i_tdata.power} + {1'b0, ROUND_HALF};
    rnd_val  = rnd_sum[WORD_W:ROUND_SHIFT];
    clip_val = (rnd_val > OUT_MAX) ? OUT_MAX : rnd_val[SAMPLE_W-1:0];
    if (i_is_power) begin
      rc_word.power = {clip_val, {SAMPLE_W{1'b0}}};
    end else begin
      rc_word = i_tdata;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (i_rst || i_soft_rst) begin
      o_tvalid <= 1'b0;
    end else if (in_hs) begin
      o_tvalid <= 1'b1;
    end else if (i_tready) begin
      o_tvalid <= 1'b0;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (in_hs) begin
      o_tdata <= rc_word;
      o_tlast <= i_tlast;
    end
  end

  // A stalled output beat must not move
  a_out_stable: assert property (@(posedge ce_clk) disable iff (i_rst || i_soft_rst)
    o_tvalid && !i_tready |=> o_tvalid && $stable(o_tdata) && $stable(o_tlast));

endmodule

/* rtl/fft_postproc.sv */
//--------------------------------------------------------------------
// Spectrum post-processor top level
//--------------------------------------------------------------------

module fft_postproc
  import fft_reg_pkg::*, fft_dsp_pkg::*;
#(
  parameter int EN_MAG_APPROX = 1,
  parameter int EN_MAG_SQ     = 1
) (
  input  logic                  ce_clk,
  input  logic                  i_rst,
  // AXI4-Lite register bus
  input  logic [REG_ADDR_W-1:0] i_awaddr,
  input  logic                  i_awvalid,
  output logic                  o_awready,
  input  logic [31:0]           i_wdata,
  input  logic                  i_wvalid,
  output logic                  o_wready,
  output logic [1:0]            o_bresp,
  output logic                  o_bvalid,
  input  logic                  i_bready,
  input  logic [REG_ADDR_W-1:0] i_araddr,
  input  logic                  i_arvalid,
  output logic                  o_arready,
  output logic [31:0]           o_rdata,
  output logic [1:0]            o_rresp,
  output logic                  o_rvalid,
  input  logic                  i_rready,
  // Sample stream in
  input  logic [WORD_W-1:0]     i_s_tdata,
  input  logic                  i_s_tlast,
  input  logic                  i_s_tvalid,
  output logic                  o_s_tready,
  // Sample stream out
  output logic [WORD_W-1:0]     o_m_tdata,
  output logic                  o_m_tlast,
  output logic                  o_m_tvalid,
  input  logic                  i_m_tready
);

  logic         soft_rst;
  out_mode_t    mode;

  // Frame mode stage to magnitude unit
  sample_word_t fm_tdata;
  logic         fm_tlast;
  logic         fm_tvalid;
  logic         fm_tready;
  out_mode_t    fm_tag;

  // Magnitude unit to rounding stage
  sample_word_t mu_tdata;
  logic         mu_tlast;
  logic         mu_tvalid;
  logic         mu_tready;
  logic         mu_is_power;

  sample_word_t rc_tdata;

  fft_regs #(
    .EN_MAG_APPROX (EN_MAG_APPROX),
    .EN_MAG_SQ     (EN_MAG_SQ)
  ) u_regs (
    .ce_clk     (ce_clk),
    .i_rst      (i_rst),
    .i_awaddr   (i_awaddr),
    .i_awvalid  (i_awvalid),
    .o_awready  (o_awready),
    .i_wdata    (i_wdata),
    .i_wvalid   (i_wvalid),
    .o_wready   (o_wready),
    .o_bresp    (o_bresp),
    .o_bvalid   (o_bvalid),
    .i_bready   (i_bready),
    .i_araddr   (i_araddr),
    .i_arvalid  (i_arvalid),
    .o_arready  (o_arready),
    .o_rdata    (o_rdata),
    .o_rresp    (o_rresp),
    .o_rvalid   (o_rvalid),
    .i_rready   (i_rready),
    .o_soft_rst (soft_rst),
    .o_mode     (mode)
  );

  fft_frame_mode u_frame_mode (
    .ce_clk     (ce_clk),
    .i_rst      (i_rst),
    .i_soft_rst (soft_rst),
    .i_mode     (mode),
    .i_tdata    (i_s_tdata),
    .i_tlast    (i_s_tlast),
    .i_tvalid   (i_s_tvalid),
    .o_tready   (o_s_tready),
    .o_tdata    (fm_tdata),
    .o_tlast    (fm_tlast),
    .o_tvalid   (fm_tvalid),
    .o_mode_tag (fm_tag),
    .i_tready   (fm_tready)
  );

  fft_mag_unit #(
    .EN_MAG_APPROX (EN_MAG_APPROX),
    .EN_MAG_SQ     (EN_MAG_SQ)
  ) u_mag_unit (
    .ce_clk     (ce_clk),
    .i_rst      (i_rst),
    .i_soft_rst (soft_rst),
    .i_tdata    (fm_tdata),
    .i_tlast    (fm_tlast),
    .i_tvalid   (fm_tvalid),
    .o_tready   (fm_tready),
    .i_mode_tag (fm_tag),
    .o_tdata    (mu_tdata),
    .o_tlast    (mu_tlast),
    .o_tvalid   (mu_tvalid),
    .o_is_power (mu_is_power),
    .i_tready   (mu_tready)
  );

  fft_round_clip u_round_clip (
    .ce_clk     (ce_clk),
    .i_rst      (i_rst),
    .i_soft_rst (soft_rst),
    .i_tdata    (mu_tdata),
    .i_tlast    (mu_tlast),
    .i_tvalid   (mu_tvalid),
    .o_tready   (mu_tready),
    .i_is_power (mu_is_power),
    .o_tdata    (rc_tdata),
    .o_tlast    (o_m_tlast),
    .o_tvalid   (o_m_tvalid),
    .i_tready   (i_m_tready)
  );

  assign o_m_tdata = rc_tdata;

endmodule

/* include/tb_axil_tasks.svh */
//--------------------------------------------------------------------
// AXI4-Lite master tasks
//--------------------------------------------------------------------

`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// Address and data go out together, each drops once it is taken
task automatic write_reg(input logic [REG_ADDR_W-1:0] addr, input logic [31:0] data);
  logic aw_take;
  logic w_take;
  @(negedge ce_clk);
  i_awaddr  = addr;
  i_awvalid = 1'b1;
  i_wdata   = data;
  i_wvalid  = 1'b1;
  i_bready  = 1'b1;
  while (i_awvalid || i_wvalid) begin
    aw_take = i_awvalid && o_awready;
    w_take  = i_wvalid && o_wready;
    @(negedge ce_clk);
    if (aw_take) begin
      i_awvalid = 1'b0;
    end
    if (w_take) begin
      i_wvalid = 1'b0;
    end
  end
  while (!o_bvalid) begin
    @(negedge ce_clk);
  end
  assert (o_bresp == AXIL_RESP_OKAY)
    else report_mismatch("o_bresp", {30'd0, o_bresp}, {30'd0, AXIL_RESP_OKAY});
  // Response is taken on the next rising edge
  @(negedge ce_clk);
  i_bready = 1'b0;
endtask

task automatic read_reg(input logic [REG_ADDR_W-1:0] addr, output logic [31:0] data);
  logic ar_take;
  @(negedge ce_clk);
  i_araddr  = addr;
  i_arvalid = 1'b1;
  i_rready  = 1'b1;
  while (i_arvalid) begin
    ar_take = o_arready;
    @(negedge ce_clk);
    if (ar_take) begin
      i_arvalid = 1'b0;
    end
  end
  while (!o_rvalid) begin
    @(negedge ce_clk);
  end
  data = o_rdata;
  assert (o_rresp == AXIL_RESP_OKAY)
    else report_mismatch("o_rresp", {30'd0, o_rresp}, {30'd0, AXIL_RESP_OKAY});
  @(negedge ce_clk);
  i_rready = 1'b0;
endtask

`endif

/* test/tb_fft_postproc.sv */
//--------------------------------------------------------------------
// Spectrum post-processor testbench
//--------------------------------------------------------------------

module tb_fft_postproc
  import fft_reg_pkg::*, fft_dsp_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 100;
  localparam int FRAME_LEN  = 8;
  localparam int N_CORNER   = 4;
  localparam int N_CPLX     = 4;
  localparam int N_SQ       = 3;
  localparam int N_MAG      = 3;
  localparam int N_MISC     = 3;
  localparam int N_STALL    = 6;
  localparam int N_AFTER    = 3;
  localparam int N_FRAMES   = N_CPLX + N_SQ + N_MAG + N_MISC + N_STALL + N_AFTER;
  localparam int PLANNED_BEATS = N_FRAMES * FRAME_LEN + 2 * N_CORNER;

  logic                  ce_clk;
  logic                  i_rst;
  logic [REG_ADDR_W-1:0] i_awaddr;
  logic                  i_awvalid;
  logic                  o_awready;
  logic [31:0]           i_wdata;
  logic                  i_wvalid;
  logic                  o_wready;
  logic [1:0]            o_bresp;
  logic                  o_bvalid;
  logic                  i_bready;
  logic [REG_ADDR_W-1:0] i_araddr;
  logic                  i_arvalid;
  logic                  o_arready;
  logic [31:0]           o_rdata;
  logic [1:0]            o_rresp;
  logic                  o_rvalid;
  logic                  i_rready;
  logic [31:0]           i_s_tdata;
  logic                  i_s_tlast;
  logic                  i_s_tvalid;
  logic                  o_s_tready;
  logic [31:0]           o_m_tdata;
  logic                  o_m_tlast;
  logic                  o_m_tvalid;
  logic                  i_m_tready;

  // Reference model state
  logic [32:0] exp_q[$];
  logic [1:0]  reg_mode;
  logic [1:0]  frame_mode_m;
  logic        at_start_m;
  logic        head_valid;
  logic [31:0] head_data;
  logic        head_last;
  logic [3:0]  acc_pipe;
  logic        beat_taken;

  // Stimulus controls
  integer      seed;
  logic        stall_en;
  logic        check_latency;
  logic        soft_on;
  logic [31:0] rd;

  fft_postproc #(
    .EN_MAG_APPROX (1),
    .EN_MAG_SQ     (1)
  ) uut (
    .ce_clk     (ce_clk),
    .i_rst      (i_rst),
    .i_awaddr   (i_awaddr),
    .i_awvalid  (i_awvalid),
    .o_awready  (o_awready),
    .i_wdata    (i_wdata),
    .i_wvalid   (i_wvalid),
    .o_wready   (o_wready),
    .o_bresp    (o_bresp),
    .o_bvalid   (o_bvalid),
    .i_bready   (i_bready),
    .i_araddr   (i_araddr),
    .i_arvalid  (i_arvalid),
    .o_arready  (o_arready),
    .o_rdata    (o_rdata),
    .o_rresp    (o_rresp),
    .o_rvalid   (o_rvalid),
    .i_rready   (i_rready),
    .i_s_tdata  (i_s_tdata),
    .i_s_tlast  (i_s_tlast),
    .i_s_tvalid (i_s_tvalid),
    .o_s_tready (o_s_tready),
    .o_m_tdata  (o_m_tdata),
    .o_m_tlast  (o_m_tlast),
    .o_m_tvalid (o_m_tvalid),
    .i_m_tready (i_m_tready)
  );

  always #(CLK_PERIOD / 2) ce_clk = ~ce_clk;

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
    $display("RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic abort_run(input string msg);
    $display("error: %s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  `include "tb_axil_tasks.svh"

  // Expected output word for the frame mode
  function automatic logic [31:0] expected_word(input logic [31:0] word, input logic [1:0] mode);
    int     re;
    int     im;
    int     a;
    int     b;
    int     mag;
    longint pw;
    longint rnd;
    re = $signed(word[31:16]);
    im = $signed(word[15:0]);
    a  = (re < 0) ? -re : re;
    b  = (im < 0) ? -im : im;
    if (mode == MODE_MAG) begin
      mag = (a > b) ? a + b / 2 : b + a / 2;
      if (mag > 32767) begin
        mag = 32767;
      end
      return {mag[15:0], 16'h0000};
    end else if (mode == MODE_MAG_SQ) begin
      pw  = longint'(a) * longint'(a) + longint'(b) * longint'(b);
      rnd = (pw + longint'(ROUND_HALF)) >>> ROUND_SHIFT;
      if (rnd > 32767) begin
        rnd = 32767;
      end
      return {rnd[15:0], 16'h0000};
    end
    return word;
  endfunction

  //--------------------------------------------------------------------
  // Reference model fed by accepted input beats
  //--------------------------------------------------------------------

  always @(posedge ce_clk) begin
    if (i_rst) begin
      exp_q.delete();
      at_start_m   = 1'b1;
      frame_mode_m = MODE_COMPLEX;
      head_valid <= 1'b0;
      acc_pipe   <= '0;
    end else begin
      if (o_m_tvalid && i_m_tready && exp_q.size() != 0) begin
        void'(exp_q.pop_front());
      end
      if (i_s_tvalid && o_s_tready) begin
        // Mode follows the register only on the first beat of a frame
        if (at_start_m) begin
          frame_mode_m = reg_mode;
        end
        at_start_m = i_s_tlast;
        exp_q.push_back({i_s_tlast, expected_word(i_s_tdata, frame_mode_m)});
      end
      head_valid <= (exp_q.size() != 0);
      if (exp_q.size() != 0) begin
        head_data <= exp_q[0][31:0];
        head_last <= exp_q[0][32];
      end
      acc_pipe <= {acc_pipe[2:0], i_s_tvalid && o_s_tready};
    end
    beat_taken <= !i_rst && i_s_tvalid && o_s_tready;
  end

  a_out_expected: assert property (@(posedge ce_clk) disable iff (i_rst)
    o_m_tvalid |-> head_valid)
    else abort_run("output beat appeared with no input beat outstanding");

  a_out_data: assert property (@(posedge ce_clk) disable iff (i_rst)
    o_m_tvalid && head_valid |-> o_m_tdata == head_data)
    else report_mismatch("o_m_tdata", $sampled(o_m_tdata), $sampled(head_data));

  a_out_last: assert property (@(posedge ce_clk) disable iff (i_rst)
    o_m_tvalid && head_valid |-> o_m_tlast == head_last)
    else report_mismatch("o_m_tlast", {31'd0, $sampled(o_m_tlast)},
                         {31'd0, $sampled(head_last)});

  // Fixed 4 cycle latency while the output never stalls
  a_latency: assert property (@(posedge ce_clk) disable iff (i_rst)
    check_latency |-> o_m_tvalid == acc_pipe[3])
    else abort_run("output beat did not arrive exactly 4 cycles after its input");

  a_soft_hold: assert property (@(posedge ce_clk) disable iff (i_rst)
    soft_on |-> !o_s_tready)
    else abort_run("stream input accepted a beat while soft reset was set");

  //--------------------------------------------------------------------
  // Stimulus helpers
  //--------------------------------------------------------------------

  task automatic pick_ready();
    logic [31:0] r;
    if (stall_en) begin
      r = $random(seed);
      i_m_tready = r[0];
    end
  endtask

  // Starts on a falling edge and returns on the falling edge after the beat is taken
  task automatic send_beat(input logic [31:0] data, input logic last);
    i_s_tdata  = data;
    i_s_tlast  = last;
    i_s_tvalid = 1'b1;
    pick_ready();
    @(negedge ce_clk);
    while (!beat_taken) begin
      pick_ready();
      @(negedge ce_clk);
    end
    i_s_tvalid = 1'b0;
  endtask

  task automatic send_random_beats(input int count, input logic close);
    logic [31:0] r;
    for (int i = 0; i < count; i++) begin
      r = $random(seed);
      send_beat(r, close && (i == count - 1));
    end
  endtask

  task automatic send_corner_frame();
    send_beat({16'h8000, 16'h8000}, 1'b0);
    send_beat({16'h7fff, 16'h0000}, 1'b0);
    send_beat({16'h0000, 16'h8000}, 1'b0);
    send_beat({16'd100, 16'hffe1}, 1'b1);
  endtask

  task automatic set_mode(input logic [1:0] m);
    write_reg(REG_MODE_ADDR, {30'd0, m});
    reg_mode = m;
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      @(negedge ce_clk);
      pick_ready();
    end
  endtask

  //--------------------------------------------------------------------
  // Test sequence
  //--------------------------------------------------------------------

  initial begin
    seed          = 32'hf4b3_deff;
    ce_clk        = 1'b0;
    i_rst         = 1'b1;
    i_awaddr      = '0;
    i_awvalid     = 1'b0;
    i_wdata       = '0;
    i_wvalid      = 1'b0;
    i_bready      = 1'b0;
    i_araddr      = '0;
    i_arvalid     = 1'b0;
    i_rready      = 1'b0;
    i_s_tdata     = '0;
    i_s_tlast     = 1'b0;
    i_s_tvalid    = 1'b0;
    i_m_tready    = 1'b1;
    reg_mode      = MODE_COMPLEX;
    stall_en      = 1'b0;
    check_latency = 1'b1;
    soft_on       = 1'b0;
    repeat (5) @(negedge ce_clk);
    i_rst = 1'b0;

    // Register reset values and read-back
    read_reg(REG_MODE_ADDR, rd);
    assert (rd == 32'd0) else report_mismatch("o_rdata", rd, 32'd0);
    read_reg(REG_CTRL_ADDR, rd);
    assert (rd == 32'd0) else report_mismatch("o_rdata", rd, 32'd0);
    read_reg(4'h8, rd);
    assert (rd == REG_BAD_READ) else report_mismatch("o_rdata", rd, REG_BAD_READ);
    set_mode(2'd3);
    read_reg(REG_MODE_ADDR, rd);
    assert (rd == 32'd3) else report_mismatch("o_rdata", rd, 32'd3);
    set_mode(MODE_COMPLEX);

    // Complex pass-through
    repeat (N_CPLX) send_random_beats(FRAME_LEN, 1'b1);

    // Magnitude squared
    set_mode(MODE_MAG_SQ);
    send_corner_frame();
    repeat (N_SQ) send_random_beats(FRAME_LEN, 1'b1);

    // Approximate magnitude
    set_mode(MODE_MAG);
    send_corner_frame();
    repeat (N_MAG) send_random_beats(FRAME_LEN, 1'b1);

    // Unused encoding behaves as complex
    set_mode(2'd3);
    send_random_beats(FRAME_LEN, 1'b1);

    // Mode change inside a frame waits for the next frame
    set_mode(MODE_MAG_SQ);
    send_random_beats(3, 1'b0);
    set_mode(MODE_MAG);
    send_random_beats(FRAME_LEN - 3, 1'b1);
    send_random_beats(FRAME_LEN, 1'b1);

    // Back-pressure
    wait_drained();
    check_latency = 1'b0;
    stall_en      = 1'b1;
    repeat (N_STALL) send_random_beats(FRAME_LEN, 1'b1);
    wait_drained();
    stall_en   = 1'b0;
    i_m_tready = 1'b1;

    // Soft reset holds the input closed
    write_reg(REG_CTRL_ADDR, 32'd1);
    soft_on    = 1'b1;
    i_s_tdata  = 32'h1234_5678;
    i_s_tlast  = 1'b0;
    i_s_tvalid = 1'b1;
    repeat (5) @(negedge ce_clk);
    i_s_tvalid = 1'b0;
    soft_on    = 1'b0;
    write_reg(REG_CTRL_ADDR, 32'd0);
    read_reg(REG_CTRL_ADDR, rd);
    assert (rd == 32'd0) else report_mismatch("o_rdata", rd, 32'd0);
    set_mode(MODE_MAG_SQ);
    repeat (N_AFTER) send_random_beats(FRAME_LEN, 1'b1);
    // Last beat leaves the pipeline 4 cycles after it is taken
    repeat (4) @(negedge ce_clk);

    if (exp_q.size() == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      abort_run("expected beats still outstanding at the end of the run");
    end
  end

  // Watchdog scaled to the total beat count
  initial begin
    #((PLANNED_BEATS * 20 + 2000) * CLK_PERIOD);
    $display("error: watchdog expired before the test sequence finished");
    $display("RESULT: FAIL");
    $fatal(1, "timeout");
  end

endmodule

/* compile.f */
+incdir+include
rtl/fft_reg_pkg.sv
rtl/fft_dsp_pkg.sv
rtl/fft_regs.sv
rtl/fft_frame_mode.sv
rtl/fft_mag_unit.sv
rtl/fft_round_clip.sv
rtl/fft_postproc.sv
test/tb_fft_postproc.sv

/* run.sh */
#!/usr/bin/env bash
# Build the spectrum post-processor testbench with Verilator and run it.
# Exits non-zero if the build fails, the simulation fails, or no pass line is printed.

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_fft_postproc -f compile.f -Mdir obj_dir -o sim_tb_fft_postproc
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

sim_out=$(./obj_dir/sim_tb_fft_postproc 2>&1)
status=$?
printf '%s\n' "$sim_out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -q '^RESULT: PASS$'; then
  exit 0
else
  echo "Pass line not found in simulation output"
  exit 1
fi
